//--- dma_xfer_pkg.sv
package dma_xfer_pkg;

   localparam int NUM_CHANNELS = 3;

   typedef logic [1:0]              chan_idx_t;
   typedef logic [NUM_CHANNELS-1:0] chan_vec_t;
   typedef logic [31:0]             word_t;
   typedef logic [31:0]             addr_t;

   localparam addr_t ADDR_STEP = 32'd4;   // bytes per word

   // one word move through the engine
   typedef enum logic [2:0] {
      ENG_IDLE,
      ENG_MEM_RD,
      ENG_DEV_WR,
      ENG_DEV_RD,
      ENG_MEM_WR,
      ENG_DONE
   } eng_state_t;

   typedef enum logic {
      ARB_PICK,
      ARB_BUSY
   } arb_state_t;

endpackage

//--- dma_regs_pkg.sv
package dma_regs_pkg;

   typedef logic [7:0] reg_addr_t;

   // channel register blocks sit at 0x00, 0x10, 0x20
   localparam reg_addr_t CHAN_STRIDE = 8'd16;
   localparam reg_addr_t MADR_OFS    = 8'h00;
   localparam reg_addr_t BCR_OFS     = 8'h04;
   localparam reg_addr_t CHCR_OFS    = 8'h08;

   localparam reg_addr_t DPCR_ADDR   = 8'h70;
   localparam reg_addr_t DICR_ADDR   = 8'h74;

   // CHCR bits
   localparam int CHCR_DIR_BIT   = 0;   // 1 = memory to device
   localparam int CHCR_STEP_BIT  = 1;   // 1 = address steps down
   localparam int CHCR_START_BIT = 24;

   // DPCR holds one nibble per channel, enable in the top bit
   localparam int DPCR_PRIO_W  = 3;
   localparam int DPCR_FIELD_W = 4;

   typedef logic [31:0] dpcr_t;
   typedef logic [DPCR_PRIO_W-1:0] prio_t;

   // DICR bits
   localparam int DICR_FORCE_BIT = 15;
   localparam int DICR_EN_LSB    = 16;
   localparam int DICR_MEN_BIT   = 23;
   localparam int DICR_FLAG_LSB  = 24;
   localparam int DICR_IRQ_BIT   = 31;

   typedef logic [31:0] dicr_t;

endpackage

//--- dma_word_if.sv
`timescale 1ns/10ps

interface dma_word_if;
   import dma_xfer_pkg::*;

   logic      grant_valid;   // arbiter holds a word for the engine
   chan_idx_t grant_chan;
   addr_t     word_addr;
   logic      to_dev;        // 1 = memory to device
   logic      word_done;     // one cycle, from the engine

   modport arb_mp (
      output grant_valid, grant_chan, word_addr, to_dev,
      input  word_done
   );

   modport eng_mp (
      input  grant_valid, grant_chan, word_addr, to_dev,
      output word_done
   );

   // reg bank only watches which channel finished a word
   modport mon_mp (
      input grant_chan, word_done
   );

endinterface

//--- dma_reg_bank.sv
`timescale 1ns/10ps

module dma_reg_bank (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  logic                   reg_wen_i,
   input  dma_regs_pkg::reg_addr_t reg_addr_i,
   input  dma_xfer_pkg::word_t    reg_wdata_i,
   output dma_xfer_pkg::word_t    reg_rdata_o,
   dma_word_if.mon_mp             word_if,
   output dma_xfer_pkg::chan_vec_t chan_req_o,
   output dma_regs_pkg::dpcr_t    dpcr_o,
   output dma_xfer_pkg::addr_t    madr_o [dma_xfer_pkg::NUM_CHANNELS],
   output dma_xfer_pkg::chan_vec_t to_dev_o,
   output dma_xfer_pkg::chan_vec_t chan_done_o,
   output logic                   dicr_wen_o,
   input  dma_regs_pkg::dicr_t    dicr_i
);
   import dma_xfer_pkg::*;
   import dma_regs_pkg::*;

   addr_t       madr_q [NUM_CHANNELS];
   logic [15:0] bcr_q  [NUM_CHANNELS];   // word count only
   word_t       chcr_q [NUM_CHANNELS];
   dpcr_t       dpcr_q;
   chan_vec_t   chan_done_q;

   reg_addr_t   blk_sel;
   reg_addr_t   blk_ofs;
   chan_idx_t   done_chan;

   assign blk_sel   = reg_addr_i / CHAN_STRIDE;
   assign blk_ofs   = reg_addr_i % CHAN_STRIDE;
   assign done_chan = word_if.grant_chan;

   assign dpcr_o      = dpcr_q;
   assign madr_o      = madr_q;
   assign chan_done_o = chan_done_q;
   assign dicr_wen_o  = reg_wen_i && (reg_addr_i == DICR_ADDR);

   always_comb begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         chan_req_o[i] = chcr_q[i][CHCR_START_BIT];
         to_dev_o[i]   = chcr_q[i][CHCR_DIR_BIT];
      end
   end

   // CPU read mux
   always_comb begin
      reg_rdata_o = '0;
      if (reg_addr_i == DPCR_ADDR) begin
         reg_rdata_o = dpcr_q;
      end
      else if (reg_addr_i == DICR_ADDR) begin
         reg_rdata_o = dicr_i;   // lives in the irq unit
      end
      else begin
         for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (blk_sel == reg_addr_t'(i)) begin
               case (blk_ofs)
                  MADR_OFS: reg_rdata_o = madr_q[i];
                  BCR_OFS:  reg_rdata_o = {16'h0000, bcr_q[i]};
                  CHCR_OFS: reg_rdata_o = chcr_q[i];
                  default:  reg_rdata_o = '0;
               endcase
            end
         end
      end
   end

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < NUM_CHANNELS; i++) begin
            madr_q[i] <= '0;
            bcr_q[i]  <= '0;
            chcr_q[i] <= '0;
         end
         dpcr_q      <= '0;
         chan_done_q <= '0;
      end
      else begin
         chan_done_q <= '0;

         // step address and count once the engine finishes a word
         if (word_if.word_done) begin
            if (chcr_q[done_chan][CHCR_STEP_BIT]) begin
               madr_q[done_chan] <= madr_q[done_chan] - ADDR_STEP;
            end
            else begin
               madr_q[done_chan] <= madr_q[done_chan] + ADDR_STEP;
            end
            bcr_q[done_chan] <= bcr_q[done_chan] - 16'd1;
            if (bcr_q[done_chan] == 16'd1) begin   // last word of the block
               chcr_q[done_chan][CHCR_START_BIT] <= 1'b0;
               chan_done_q[done_chan]            <= 1'b1;
            end
         end

         // a CPU write in the same cycle wins
         if (reg_wen_i) begin
            if (reg_addr_i == DPCR_ADDR) begin
               dpcr_q <= reg_wdata_i;
            end
            for (int i = 0; i < NUM_CHANNELS; i++) begin
               if (blk_sel == reg_addr_t'(i)) begin
                  case (blk_ofs)
                     MADR_OFS: madr_q[i] <= reg_wdata_i;
                     BCR_OFS:  bcr_q[i]  <= reg_wdata_i[15:0];   // block count dropped
                     CHCR_OFS: chcr_q[i] <= reg_wdata_i;
                     default:  ;
                  endcase
               end
            end
         end
      end
   end

endmodule

//--- dma_arbiter.sv
`timescale 1ns/10ps

module dma_arbiter (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  dma_xfer_pkg::chan_vec_t chan_req_i,
   input  dma_regs_pkg::dpcr_t    dpcr_i,
   input  dma_xfer_pkg::addr_t    madr_i [dma_xfer_pkg::NUM_CHANNELS],
   input  dma_xfer_pkg::chan_vec_t to_dev_i,
   dma_word_if.arb_mp             word_if
);
   import dma_xfer_pkg::*;
   import dma_regs_pkg::*;

   arb_state_t state_q;
   logic       pick_found;
   chan_idx_t  pick_chan;
   prio_t      best_prio;

   // lowest priority value wins, lower index on a tie
   always_comb begin
      pick_found = 1'b0;
      pick_chan  = '0;
      best_prio  = '1;
      for (int i = 0; i < NUM_CHANNELS; i++) begin
         if (chan_req_i[i] && dpcr_i[i*DPCR_FIELD_W + DPCR_FIELD_W - 1]) begin
            if (!pick_found || (dpcr_i[i*DPCR_FIELD_W +: DPCR_PRIO_W] < best_prio)) begin
               pick_found = 1'b1;
               pick_chan  = chan_idx_t'(i);
               best_prio  = dpcr_i[i*DPCR_FIELD_W +: DPCR_PRIO_W];
            end
         end
      end
   end

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         state_q             <= ARB_PICK;
         word_if.grant_valid <= 1'b0;
         word_if.grant_chan  <= '0;
         word_if.word_addr   <= '0;
         word_if.to_dev      <= 1'b0;
      end
      else begin
         case (state_q)
            ARB_PICK: begin
               if (pick_found) begin
                  word_if.grant_valid <= 1'b1;
                  word_if.grant_chan  <= pick_chan;
                  word_if.word_addr   <= madr_i[pick_chan];
                  word_if.to_dev      <= to_dev_i[pick_chan];
                  state_q             <= ARB_BUSY;
               end
            end
            ARB_BUSY: begin
               if (word_if.word_done) begin   // re-arbitrate every word
                  word_if.grant_valid <= 1'b0;
                  state_q             <= ARB_PICK;
               end
            end
            default: state_q <= ARB_PICK;
         endcase
      end
   end

endmodule

//--- dma_word_engine.sv
`timescale 1ns/10ps

module dma_word_engine (
   input  logic                   sys_clk,
   input  logic                   rst,
   dma_word_if.eng_mp             word_if,
   output logic                   mem_ren_o,
   output logic                   mem_wen_o,
   output dma_xfer_pkg::addr_t    mem_addr_o,
   output dma_xfer_pkg::word_t    mem_wdata_o,
   input  dma_xfer_pkg::word_t    mem_rdata_i,
   input  logic                   mem_ack_i,
   input  dma_xfer_pkg::chan_vec_t dev_rdy_i,
   input  dma_xfer_pkg::chan_vec_t dev_full_i,
   input  dma_xfer_pkg::word_t    dev_rdata_i [dma_xfer_pkg::NUM_CHANNELS],
   output dma_xfer_pkg::chan_vec_t dev_ren_o,
   output dma_xfer_pkg::chan_vec_t dev_wen_o,
   output dma_xfer_pkg::word_t    dev_wdata_o
);
   import dma_xfer_pkg::*;

   eng_state_t state_q;
   word_t      data_q;       // word in flight
   addr_t      addr_q;
   logic       done_q;
   chan_idx_t  chan;
   logic       dev_rd_go;
   logic       dev_wr_go;

   assign chan = word_if.grant_chan;

   assign dev_rd_go = (state_q == ENG_DEV_RD) && dev_rdy_i[chan];
   assign dev_wr_go = (state_q == ENG_DEV_WR) && !dev_full_i[chan];

   assign word_if.word_done = done_q;
   assign mem_addr_o        = addr_q;
   assign mem_wdata_o       = data_q;
   assign dev_wdata_o       = data_q;

   // single-cycle strobes, granted channel only
   always_comb begin
      dev_ren_o       = '0;
      dev_wen_o       = '0;
      dev_ren_o[chan] = dev_rd_go;
      dev_wen_o[chan] = dev_wr_go;
   end

   // address and data of the current word
   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         addr_q <= '0;
         data_q <= '0;
      end
      else begin
         if (state_q == ENG_IDLE && word_if.grant_valid) begin
            addr_q <= word_if.word_addr;
         end
         if (state_q == ENG_MEM_RD && mem_ack_i) begin
            data_q <= mem_rdata_i;
         end
         if (dev_rd_go) begin
            data_q <= dev_rdata_i[chan];
         end
      end
   end

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         state_q   <= ENG_IDLE;
         mem_ren_o <= 1'b0;
         mem_wen_o <= 1'b0;
         done_q    <= 1'b0;
      end
      else begin
         done_q <= 1'b0;
         case (state_q)
            ENG_IDLE: begin
               if (word_if.grant_valid) begin
                  if (word_if.to_dev) begin
                     mem_ren_o <= 1'b1;
                     state_q   <= ENG_MEM_RD;
                  end
                  else begin
                     state_q <= ENG_DEV_RD;
                  end
               end
            end
            ENG_MEM_RD: begin
               if (mem_ack_i) begin   // data captured on this edge
                  mem_ren_o <= 1'b0;
                  state_q   <= ENG_DEV_WR;
               end
            end
            ENG_DEV_WR: begin
               if (dev_wr_go) begin
                  done_q  <= 1'b1;
                  state_q <= ENG_DONE;
               end
            end
            ENG_DEV_RD: begin
               if (dev_rd_go) begin
                  mem_wen_o <= 1'b1;
                  state_q   <= ENG_MEM_WR;
               end
            end
            ENG_MEM_WR: begin
               if (mem_ack_i) begin
                  mem_wen_o <= 1'b0;
                  done_q    <= 1'b1;
                  state_q   <= ENG_DONE;
               end
            end
            ENG_DONE: state_q <= ENG_IDLE;   // grant drops on this edge
            default:  state_q <= ENG_IDLE;
         endcase
      end
   end

endmodule

//--- dma_irq_unit.sv
`timescale 1ns/10ps

module dma_irq_unit (
   input  logic                   sys_clk,
   input  logic                   rst,
   input  logic                   dicr_wen_i,
   input  dma_xfer_pkg::word_t    wdata_i,
   input  dma_xfer_pkg::chan_vec_t chan_done_i,
   output dma_regs_pkg::dicr_t    dicr_o,
   output logic                   irq_o
);
   import dma_xfer_pkg::*;
   import dma_regs_pkg::*;

   logic      force_q;
   logic      men_q;
   chan_vec_t en_q;
   chan_vec_t flag_q;
   chan_vec_t flag_set;

   // completion only counts when master and channel enable are both on
   assign flag_set = chan_done_i & en_q & {NUM_CHANNELS{men_q}};

   always_ff @(posedge sys_clk or posedge rst) begin
      if (rst) begin
         force_q <= 1'b0;
         men_q   <= 1'b0;
         en_q    <= '0;
         flag_q  <= '0;
      end
      else if (dicr_wen_i) begin
         force_q <= wdata_i[DICR_FORCE_BIT];
         men_q   <= wdata_i[DICR_MEN_BIT];
         en_q    <= wdata_i[DICR_EN_LSB +: NUM_CHANNELS];
         // write 1 clears, a completion in the same cycle still lands
         flag_q  <= (flag_q & ~wdata_i[DICR_FLAG_LSB +: NUM_CHANNELS]) | flag_set;
      end
      else begin
         flag_q <= flag_q | flag_set;
      end
   end

   assign irq_o = force_q | (|(flag_q & en_q));

   always_comb begin
      dicr_o                                    = '0;
      dicr_o[DICR_FORCE_BIT]                    = force_q;
      dicr_o[DICR_EN_LSB +: NUM_CHANNELS]       = en_q;
      dicr_o[DICR_MEN_BIT]                      = men_q;
      dicr_o[DICR_FLAG_LSB +: NUM_CHANNELS]     = flag_q;
      dicr_o[DICR_IRQ_BIT]                      = irq_o;
   end

endmodule

//--- psx_dma_top.sv
`timescale 1ns/10ps

module psx_dma_top (
   input  logic                   sys_clk,
   input  logic                   rst,
   // CPU register port
   input  logic                   reg_wen_i,
   input  dma_regs_pkg::reg_addr_t reg_addr_i,
   input  dma_xfer_pkg::word_t    reg_wdata_i,
   output dma_xfer_pkg::word_t    reg_rdata_o,
   // memory port
   output logic                   mem_ren_o,
   output logic                   mem_wen_o,
   output dma_xfer_pkg::addr_t    mem_addr_o,
   output dma_xfer_pkg::word_t    mem_wdata_o,
   input  dma_xfer_pkg::word_t    mem_rdata_i,
   input  logic                   mem_ack_i,
   // device ports
   input  dma_xfer_pkg::chan_vec_t dev_rdy_i,
   input  dma_xfer_pkg::chan_vec_t dev_full_i,
   output dma_xfer_pkg::chan_vec_t dev_ren_o,
   output dma_xfer_pkg::chan_vec_t dev_wen_o,
   input  dma_xfer_pkg::word_t    dev_rdata_i [dma_xfer_pkg::NUM_CHANNELS],
   output dma_xfer_pkg::word_t    dev_wdata_o,
   output logic                   irq_o
);
   import dma_xfer_pkg::*;
   import dma_regs_pkg::*;

   chan_vec_t chan_req;
   chan_vec_t to_dev;
   chan_vec_t chan_done;
   dpcr_t     dpcr;
   dicr_t     dicr;
   addr_t     madr [NUM_CHANNELS];
   logic      dicr_wen;

   dma_word_if word_if ();

   dma_reg_bank u_reg_bank (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .reg_wen_i   (reg_wen_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .reg_rdata_o (reg_rdata_o),
      .word_if     (word_if.mon_mp),
      .chan_req_o  (chan_req),
      .dpcr_o      (dpcr),
      .madr_o      (madr),
      .to_dev_o    (to_dev),
      .chan_done_o (chan_done),
      .dicr_wen_o  (dicr_wen),
      .dicr_i      (dicr)
   );

   dma_arbiter u_arbiter (
      .sys_clk    (sys_clk),
      .rst        (rst),
      .chan_req_i (chan_req),
      .dpcr_i     (dpcr),
      .madr_i     (madr),
      .to_dev_i   (to_dev),
      .word_if    (word_if.arb_mp)
   );

   dma_word_engine u_engine (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .word_if     (word_if.eng_mp),
      .mem_ren_o   (mem_ren_o),
      .mem_wen_o   (mem_wen_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o),
      .mem_rdata_i (mem_rdata_i),
      .mem_ack_i   (mem_ack_i),
      .dev_rdy_i   (dev_rdy_i),
      .dev_full_i  (dev_full_i),
      .dev_rdata_i (dev_rdata_i),
      .dev_ren_o   (dev_ren_o),
      .dev_wen_o   (dev_wen_o),
      .dev_wdata_o (dev_wdata_o)
   );

   dma_irq_unit u_irq (
      .sys_clk     (sys_clk),
      .rst         (rst),
      .dicr_wen_i  (dicr_wen),
      .wdata_i     (reg_wdata_i),
      .chan_done_i (chan_done),
      .dicr_o      (dicr),
      .irq_o       (irq_o)
   );

endmodule

//--- tb_psx_dma.sv
`timescale 1ns/10ps

module tb_psx_dma;
   import dma_xfer_pkg::*;
   import dma_regs_pkg::*;

   localparam int CLK_PERIOD      = 8;
   localparam int TOTAL_WORDS     = 31;   // all blocks of all tests
   localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 2000;

   logic      sys_clk;
   logic      rst;
   logic      reg_wen_i;
   reg_addr_t reg_addr_i;
   word_t     reg_wdata_i;
   word_t     reg_rdata_o;
   logic      mem_ren_o;
   logic      mem_wen_o;
   addr_t     mem_addr_o;
   word_t     mem_wdata_o;
   word_t     mem_rdata_i;
   logic      mem_ack_i;
   chan_vec_t dev_rdy_i;
   chan_vec_t dev_full_i;
   chan_vec_t dev_ren_o;
   chan_vec_t dev_wen_o;
   word_t     dev_rdata_i [NUM_CHANNELS];
   word_t     dev_wdata_o;
   logic      irq_o;

   logic [31:0] lfsr_q;
   logic [1:0]  mem_wait;              // ack delay still to run
   logic        mem_busy;
   chan_vec_t   rd_taken;              // device read strobes before the edge
   logic [15:0] dev_cnt [NUM_CHANNELS];

   word_t     dev_exp_q [$];           // words the devices should receive
   chan_idx_t dev_chan_q [$];
   addr_t     wr_addr_q [$];           // memory writes still expected
   word_t     wr_data_q [$];
   chan_idx_t access_log [$];          // channel of each memory access

   psx_dma_top UUT (.*);

   always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic take_bit();
      lfsr_q = lfsr_next(lfsr_q);
      return lfsr_q[0];
   endfunction

   // memory content, fixed mix of the whole address
   function automatic word_t exp_mem_word(input addr_t a);
      return (a * 32'h9E37_79B9) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_0F0F;
   endfunction

   function automatic word_t dev_word(input chan_idx_t c, input logic [15:0] k);
      return {6'b110100, c, 8'h5A, k};
   endfunction

   function automatic chan_idx_t chan_of_addr(input addr_t a);
      return a[17:16];   // one 64 KiB region per channel
   endfunction

   function automatic reg_addr_t chan_reg(input chan_idx_t c, input reg_addr_t ofs);
      return reg_addr_t'(c) * CHAN_STRIDE + ofs;
   endfunction

   function automatic word_t chcr_value(input logic to_dev, input logic down,
                                        input logic start);
      word_t v;
      v                 = '0;
      v[CHCR_DIR_BIT]   = to_dev;
      v[CHCR_STEP_BIT]  = down;
      v[CHCR_START_BIT] = start;
      return v;
   endfunction

   function automatic word_t dpcr_field(input int c, input logic [2:0] prio, input logic en);
      word_t v;
      v                                    = '0;
      v[c*DPCR_FIELD_W +: DPCR_PRIO_W]     = prio;
      v[c*DPCR_FIELD_W + DPCR_FIELD_W - 1] = en;
      return v;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("** FAIL **");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_addr(input string name, input addr_t got, input addr_t exp);
      if (got !== exp) stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic write_reg(input reg_addr_t a, input word_t d);
      @(posedge sys_clk);
      #1;
      reg_wen_i   = 1'b1;
      reg_addr_i  = a;
      reg_wdata_i = d;
      @(posedge sys_clk);
      #1;
      reg_wen_i = 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t a, output word_t d);
      @(posedge sys_clk);
      #1;
      reg_addr_i = a;
      #2;
      d = reg_rdata_o;   // read mux is combinational
   endtask

   task automatic check_irq(input logic exp);
      @(posedge sys_clk);
      #3;
      check_flag("irq_o", irq_o, exp);
   endtask

   task automatic program_chan(input chan_idx_t c, input addr_t madr, input word_t bcr,
                               input word_t chcr);
      write_reg(chan_reg(c, MADR_OFS), madr);
      write_reg(chan_reg(c, BCR_OFS), bcr);
      write_reg(chan_reg(c, CHCR_OFS), chcr);
   endtask

   // queue what the models should see, then start the channel
   task automatic start_block(input chan_idx_t c, input addr_t madr0, input int n,
                              input logic to_dev, input logic down);
      addr_t a;
      a = madr0;
      for (int k = 0; k < n; k++) begin
         if (to_dev) begin
            dev_exp_q.push_back(exp_mem_word(a));
            dev_chan_q.push_back(c);
         end
         else begin
            wr_addr_q.push_back(a);
            wr_data_q.push_back(dev_word(c, dev_cnt[c] + 16'(k)));
         end
         a = down ? a - 32'd4 : a + 32'd4;
      end
      program_chan(c, madr0, word_t'(n), chcr_value(to_dev, down, 1'b1));
   endtask

   // poll the start bits until every channel in the mask has finished
   task automatic wait_idle(input chan_vec_t mask);
      word_t     d;
      chan_vec_t busy;
      busy = mask;
      while (busy != '0) begin
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (busy[c]) begin
               read_reg(chan_reg(chan_idx_t'(c), CHCR_OFS), d);
               busy[c] = d[CHCR_START_BIT];
            end
         end
      end
      repeat (2) @(posedge sys_clk);
      check_word("device words left", word_t'(dev_exp_q.size()), '0);
      check_word("memory writes left", word_t'(wr_addr_q.size()), '0);
   endtask

   task automatic run_priority(input logic [2:0] p0, input logic [2:0] p2,
                               input chan_idx_t fav);
      word_t d;
      write_reg(DPCR_ADDR, '0);   // hold all requests back
      access_log.delete();
      start_block(2'd0, 32'h0000_8000, 4, 1'b0, 1'b1);
      start_block(2'd2, 32'h0002_0100, 4, 1'b1, 1'b0);
      program_chan(2'd1, 32'h0001_0200, 32'd3, chcr_value(1'b1, 1'b0, 1'b1));
      write_reg(DPCR_ADDR, dpcr_field(0, p0, 1'b1) | dpcr_field(1, 3'd0, 1'b0)
                           | dpcr_field(2, p2, 1'b1));
      wait_idle(3'b101);
      check_word("memory access count", word_t'(access_log.size()), 32'd8);
      for (int k = 0; k < access_log.size(); k++) begin
         if (k < 4) check_flag($sformatf("access %0d by favored channel", k),
                               access_log[k] == fav, 1'b1);
         check_flag($sformatf("access %0d by disabled channel", k), access_log[k] == 2'd1, 1'b0);
      end
      read_reg(chan_reg(2'd1, CHCR_OFS), d);
      check_flag("CHCR1 start", d[CHCR_START_BIT], 1'b1);
      read_reg(chan_reg(2'd1, BCR_OFS), d);
      check_word("BCR1", d, 32'd3);
      write_reg(chan_reg(2'd1, CHCR_OFS), '0);
   endtask

   // device strobes are stable from just after the edge until the next one
   always @(negedge sys_clk) begin
      rd_taken = dev_ren_o;
      if (dev_wen_o != '0) begin
         if (dev_exp_q.size() == 0) stop_run("device write strobe with no word expected");
         check_word("dev_wen_o", word_t'(dev_wen_o), word_t'(1) << dev_chan_q.pop_front());
         check_word("dev_wdata_o", dev_wdata_o, dev_exp_q.pop_front());
      end
   end

   // memory and device models, one process so the LFSR order is fixed
   always @(posedge sys_clk) begin
      #1;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (rd_taken[c]) dev_cnt[c] = dev_cnt[c] + 16'd1;
         dev_rdata_i[c] = dev_word(chan_idx_t'(c), dev_cnt[c]);
         dev_full_i[c]  = take_bit() & take_bit();   // full a quarter of the time
         dev_rdy_i[c]   = take_bit() | take_bit();
      end
      if (mem_ack_i) begin
         mem_ack_i = 1'b0;   // taken on the edge just past
      end
      else if (mem_ren_o || mem_wen_o) begin
         if (!mem_busy) begin
            mem_busy    = 1'b1;
            mem_wait[1] = take_bit();
            mem_wait[0] = take_bit();
         end
         if (mem_wait == 2'd0) begin
            access_log.push_back(chan_of_addr(mem_addr_o));
            if (mem_ren_o) begin
               mem_rdata_i = exp_mem_word(mem_addr_o);
            end
            else begin
               if (wr_addr_q.size() == 0) stop_run("memory write with no word expected");
               check_addr("mem_addr_o", mem_addr_o, wr_addr_q.pop_front());
               check_word("mem_wdata_o", mem_wdata_o, wr_data_q.pop_front());
            end
            mem_ack_i = 1'b1;
            mem_busy  = 1'b0;
         end
         else begin
            mem_wait = mem_wait - 2'd1;
         end
      end
   end

   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      stop_run("watchdog timeout, the transfers never finished");
   end

   initial begin
      word_t d;
      word_t men_bit;
      word_t en2_bit;
      word_t flag2_bit;
      word_t force_bit;
      men_bit     = word_t'(1) << DICR_MEN_BIT;
      en2_bit     = word_t'(1) << (DICR_EN_LSB + 2);
      flag2_bit   = word_t'(1) << (DICR_FLAG_LSB + 2);
      force_bit   = word_t'(1) << DICR_FORCE_BIT;
      sys_clk     = 1'b0;
      rst         = 1'b1;
      reg_wen_i   = 1'b0;
      reg_addr_i  = '0;
      reg_wdata_i = '0;
      mem_rdata_i = '0;
      mem_ack_i   = 1'b0;
      mem_busy    = 1'b0;
      mem_wait    = '0;
      rd_taken    = '0;
      dev_rdy_i   = '0;
      dev_full_i  = '0;
      lfsr_q      = 32'd68576;
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         dev_cnt[c]     = '0;
         dev_rdata_i[c] = dev_word(chan_idx_t'(c), 16'd0);
      end
      repeat (2) @(posedge sys_clk);
      #1;
      rst = 1'b0;

      // register readback, no start bits so nothing moves
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         program_chan(chan_idx_t'(c), 32'h1357_9BD0 + 32'(c * 16), 32'h0000_0A00 + 32'(c),
                      32'h0050_0003 ^ 32'(c));
      end
      write_reg(DPCR_ADDR, 32'h0765_4321);
      write_reg(DICR_ADDR, 32'h0787_0000);   // flag bits are write-1-to-clear
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         read_reg(chan_reg(chan_idx_t'(c), MADR_OFS), d);
         check_addr($sformatf("MADR%0d", c), d, 32'h1357_9BD0 + 32'(c * 16));
         read_reg(chan_reg(chan_idx_t'(c), BCR_OFS), d);
         check_word($sformatf("BCR%0d", c), d, 32'h0000_0A00 + 32'(c));
         read_reg(chan_reg(chan_idx_t'(c), CHCR_OFS), d);
         check_word($sformatf("CHCR%0d", c), d, 32'h0050_0003 ^ 32'(c));
      end
      read_reg(DPCR_ADDR, d);
      check_word("DPCR", d, 32'h0765_4321);
      read_reg(DICR_ADDR, d);
      check_word("DICR", d, men_bit | (32'h7 << DICR_EN_LSB));
      write_reg(DICR_ADDR, '0);

      // memory to device, stepping up
      write_reg(DPCR_ADDR, dpcr_field(0, 3'd0, 1'b1) | dpcr_field(1, 3'd0, 1'b1)
                           | dpcr_field(2, 3'd0, 1'b1));
      start_block(2'd1, 32'h0001_0040, 5, 1'b1, 1'b0);
      wait_idle(3'b010);
      read_reg(chan_reg(2'd1, MADR_OFS), d);
      check_addr("MADR1", d, 32'h0001_0040 + 32'd20);
      read_reg(chan_reg(2'd1, BCR_OFS), d);
      check_word("BCR1", d, '0);
      read_reg(chan_reg(2'd1, CHCR_OFS), d);
      check_flag("CHCR1 start", d[CHCR_START_BIT], 1'b0);

      // device to memory, stepping down
      start_block(2'd0, 32'h0000_8000, 6, 1'b0, 1'b1);
      wait_idle(3'b001);
      read_reg(chan_reg(2'd0, MADR_OFS), d);
      check_addr("MADR0", d, 32'h0000_8000 - 32'd24);

      run_priority(3'd5, 3'd1, 2'd2);
      run_priority(3'd3, 3'd3, 2'd0);   // tie goes to the lower index

      // interrupt flags
      write_reg(DICR_ADDR, men_bit | en2_bit);
      start_block(2'd2, 32'h0002_0400, 2, 1'b1, 1'b0);
      wait_idle(3'b100);
      read_reg(DICR_ADDR, d);
      check_flag("DICR flag 2", d[DICR_FLAG_LSB + 2], 1'b1);
      check_irq(1'b1);
      write_reg(DICR_ADDR, men_bit | en2_bit | flag2_bit);
      read_reg(DICR_ADDR, d);
      check_flag("DICR flag 2", d[DICR_FLAG_LSB + 2], 1'b0);
      check_irq(1'b0);
      write_reg(DICR_ADDR, men_bit);
      start_block(2'd2, 32'h0002_0500, 2, 1'b1, 1'b0);
      wait_idle(3'b100);
      read_reg(DICR_ADDR, d);
      check_flag("DICR flag 2", d[DICR_FLAG_LSB + 2], 1'b0);
      check_irq(1'b0);
      write_reg(DICR_ADDR, force_bit);
      check_irq(1'b1);
      read_reg(DICR_ADDR, d);
      check_flag("DICR irq bit", d[DICR_IRQ_BIT], 1'b1);
      write_reg(DICR_ADDR, '0);
      check_irq(1'b0);

      $display("** PASS **");
      $finish;
   end

endmodule

//--- psx_dma_top.f
dma_xfer_pkg.sv
dma_regs_pkg.sv
dma_word_if.sv
dma_reg_bank.sv
dma_arbiter.sv
dma_word_engine.sv
dma_irq_unit.sv
psx_dma_top.sv
tb_psx_dma.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_psx_dma
FLIST     := psx_dma_top.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter %.sv %.v,$(shell cat $(FLIST)))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
